// File: hdl/bp_pkg.sv
package bp_pkg;

    // fetch group and resolve bundle width
    localparam int FETCH_WIDTH = 4;

    // branch target buffer geometry
    localparam int BTB_ENTRIES    = 16;
    localparam int BTB_INDEX_BITS = 4;
    localparam int BTB_TAG_BITS   = 26;

    // branch history table geometry
    localparam int BHT_ENTRIES    = 16;
    localparam int BHT_INDEX_BITS = 4;

    // local history length, one pattern entry per history value
    localparam int HISTORY_BITS = 4;
    localparam int PHT_ENTRIES  = 2 ** HISTORY_BITS;

    // instruction address, byte granular
    typedef logic [31:0] addr_t;

    // target buffer index and tag fields
    typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [BTB_TAG_BITS-1:0]   btb_tag_t;

    // history table index
    typedef logic [BHT_INDEX_BITS-1:0] bht_index_t;

    // newest outcome in bit 0
    typedef logic [HISTORY_BITS-1:0] history_t;

    // one-bit last-outcome pattern entry
    typedef enum logic {
        NOT_TAKEN = 1'b0,
        TAKEN     = 1'b1
    } dir_state_t;

    // one resolved branch from the back end
    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t pc;
        addr_t target;
    } resolve_t;

    typedef resolve_t [FETCH_WIDTH-1:0] resolve_bundle_t;

    // per-lane answer to fetch
    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t target;
    } prediction_t;

    typedef prediction_t [FETCH_WIDTH-1:0] prediction_group_t;

endpackage

// File: hdl/branch_target_buffer.sv
`timescale 1ns/10ps

module branch_target_buffer (
    input  logic                                     clock,
    input  logic                                     reset,
    input  bp_pkg::addr_t                            pc_start,
    input  bp_pkg::resolve_bundle_t                  resolve,
    output logic          [bp_pkg::FETCH_WIDTH-1:0]  hits,
    output bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  targets
);

    import bp_pkg::*;

    // stored payload of one entry
    typedef struct packed {
        btb_tag_t tag;
        addr_t    target;
    } btb_entry_t;

    btb_entry_t [BTB_ENTRIES-1:0] entries;
    logic       [BTB_ENTRIES-1:0] entry_valid;

    addr_t      [FETCH_WIDTH-1:0] lane_pc;
    btb_index_t [FETCH_WIDTH-1:0] lane_index;
    btb_tag_t   [FETCH_WIDTH-1:0] lane_tag;
    btb_index_t [FETCH_WIDTH-1:0] slot_index;
    btb_tag_t   [FETCH_WIDTH-1:0] slot_tag;

    // lane addresses and resolve slot fields
    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_fields
        assign lane_pc[i]    = pc_start + addr_t'(4 * i);
        assign lane_index[i] = lane_pc[i][BTB_INDEX_BITS+1:2];
        assign lane_tag[i]   = lane_pc[i][31:BTB_INDEX_BITS+2];
        assign slot_index[i] = resolve[i].pc[BTB_INDEX_BITS+1:2];
        assign slot_tag[i]   = resolve[i].pc[31:BTB_INDEX_BITS+2];
    end

    // lookup sees the registered contents only
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            hits[i]    = entry_valid[lane_index[i]] &&
                         (entries[lane_index[i]].tag == lane_tag[i]);
            targets[i] = entries[lane_index[i]].target;
        end
    end

    // valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (resolve[i].valid && resolve[i].taken) begin
                    entry_valid[slot_index[i]] <= 1'b1;
                end
            end
        end
    end

    // tag and target, later slots overwrite earlier ones
    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (resolve[i].valid && resolve[i].taken) begin
                entries[slot_index[i]].tag    <= slot_tag[i];
                entries[slot_index[i]].target <= resolve[i].target;
            end
        end
    end

endmodule

// File: hdl/local_history_predictor.sv
`timescale 1ns/10ps

module local_history_predictor (
    input  logic                              clock,
    input  logic                              reset,
    input  bp_pkg::addr_t                     pc_start,
    input  bp_pkg::resolve_bundle_t           resolve,
    output logic [bp_pkg::FETCH_WIDTH-1:0]    dir_taken
);

    import bp_pkg::*;

    // branch history table, one local history per entry
    history_t [BHT_ENTRIES-1:0] history_table;
    history_t [BHT_ENTRIES-1:0] next_history_table;

    // pattern history table, indexed by a local history
    dir_state_t [PHT_ENTRIES-1:0] pattern_table;
    dir_state_t [PHT_ENTRIES-1:0] next_pattern_table;

    addr_t      [FETCH_WIDTH-1:0] lane_pc;
    bht_index_t [FETCH_WIDTH-1:0] lane_index;
    bht_index_t [FETCH_WIDTH-1:0] slot_index;
    history_t   [FETCH_WIDTH-1:0] lane_history;

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_fields
        assign lane_pc[i]    = pc_start + addr_t'(4 * i);
        assign lane_index[i] = lane_pc[i][BHT_INDEX_BITS+1:2];
        assign slot_index[i] = resolve[i].pc[BHT_INDEX_BITS+1:2];
    end

    // two-level lookup on the registered tables
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_history[i] = history_table[lane_index[i]];
            dir_taken[i]    = (pattern_table[lane_history[i]] == TAKEN);
        end
    end

    // training in slot order
    always_comb begin
        next_history_table = history_table;
        next_pattern_table = pattern_table;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (resolve[i].valid) begin
                // chained so that slots sharing an index shift in sequence
                next_history_table[slot_index[i]] = {
                    next_history_table[slot_index[i]][HISTORY_BITS-2:0],
                    resolve[i].taken
                };
                // pattern entry picked by the pre-update history
                next_pattern_table[history_table[slot_index[i]]] =
                    resolve[i].taken ? TAKEN : NOT_TAKEN;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history_table <= '0;
            for (int e = 0; e < PHT_ENTRIES; e++) begin
                pattern_table[e] <= NOT_TAKEN;
            end
        end else begin
            history_table <= next_history_table;
            pattern_table <= next_pattern_table;
        end
    end

endmodule

// File: hdl/fetch_target_select.sv
`timescale 1ns/10ps

module fetch_target_select (
    input  bp_pkg::addr_t                            pc_start,
    input  logic          [bp_pkg::FETCH_WIDTH-1:0]  dir_taken,
    input  logic          [bp_pkg::FETCH_WIDTH-1:0]  hits,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  targets,
    output bp_pkg::prediction_group_t                predictions
);

    import bp_pkg::*;

    addr_t [FETCH_WIDTH-1:0] lane_pc;
    addr_t [FETCH_WIDTH-1:0] fall_through;
    logic  [FETCH_WIDTH-1:0] lane_redirect;
    logic                    taken_seen;

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_lanes
        assign lane_pc[i]       = pc_start + addr_t'(4 * i);
        assign fall_through[i]  = lane_pc[i] + addr_t'(4);
        // direction alone is not enough, a target must be known
        assign lane_redirect[i] = dir_taken[i] && hits[i];
    end

    always_comb begin
        taken_seen = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            predictions[i].valid = !taken_seen;
            predictions[i].taken = !taken_seen && lane_redirect[i];
            if (predictions[i].taken) begin
                predictions[i].target = targets[i];
            end else begin
                predictions[i].target = fall_through[i];
            end
            // everything past the first taken lane is squashed
            if (lane_redirect[i]) begin
                taken_seen = 1'b1;
            end
        end
    end

endmodule

// File: hdl/branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor (
    input  logic                       clock,
    input  logic                       reset,
    input  bp_pkg::addr_t              pc_start,
    input  bp_pkg::resolve_bundle_t    resolve,
    output bp_pkg::prediction_group_t  predictions
);

    import bp_pkg::*;

    // per-lane direction from the local predictor
    logic [FETCH_WIDTH-1:0] dir_taken;

    // per-lane target buffer answer
    logic  [FETCH_WIDTH-1:0] hits;
    addr_t [FETCH_WIDTH-1:0] targets;

    local_history_predictor u_local_history_predictor (
        .clock     (clock),
        .reset     (reset),
        .pc_start  (pc_start),
        .resolve   (resolve),
        .dir_taken (dir_taken)
    );

    branch_target_buffer u_branch_target_buffer (
        .clock    (clock),
        .reset    (reset),
        .pc_start (pc_start),
        .resolve  (resolve),
        .hits     (hits),
        .targets  (targets)
    );

    fetch_target_select u_fetch_target_select (
        .pc_start    (pc_start),
        .dir_taken   (dir_taken),
        .hits        (hits),
        .targets     (targets),
        .predictions (predictions)
    );

endmodule

// File: sim/branch_predictor_checker.sv
`timescale 1ns/10ps

module branch_predictor_checker (
    input logic                      clock,
    input logic                      reset,
    input bp_pkg::prediction_group_t predictions
);

    import bp_pkg::*;

    logic [FETCH_WIDTH-1:0] lane_valid;
    logic [FETCH_WIDTH-1:0] lane_taken;

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_fields
        assign lane_valid[i] = predictions[i].valid;
        assign lane_taken[i] = predictions[i].taken;
    end

    // first lane is never squashed
    lane0_valid: assert property (@(posedge clock) disable iff (reset) lane_valid[0])
        else $error("lane 0 prediction is not valid");

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_lanes
        taken_is_valid: assert property (@(posedge clock) disable iff (reset)
            lane_taken[i] |-> lane_valid[i])
            else $error("lane %0d taken but not valid", i);

        if (i < FETCH_WIDTH - 1) begin : g_after
            squash_after_taken: assert property (@(posedge clock) disable iff (reset)
                lane_taken[i] |-> !(|lane_valid[FETCH_WIDTH-1:i+1]))
                else $error("lane valid after taken lane %0d", i);
        end
    end

endmodule

bind branch_predictor branch_predictor_checker u_branch_predictor_checker (
    .clock       (clock),
    .reset       (reset),
    .predictions (predictions)
);

// File: sim/branch_predictor_tb.sv
`timescale 1ns/10ps

module branch_predictor_tb;

    import bp_pkg::*;

    // run limit in clock cycles, well above the length of all tests
    localparam int MAX_CYCLES     = 2000;
    localparam int RANDOM_BUNDLES = 200;

    // A and B share index 2 but not the tag
    localparam addr_t ADDR_A   = 32'h0000_1048;
    localparam addr_t TARGET_A = 32'h0000_2000;
    localparam addr_t ADDR_B   = 32'h0000_1088;
    // C and D share index 4, E sits at index 5
    localparam addr_t ADDR_C   = 32'h0000_3010;
    localparam addr_t ADDR_D   = 32'h0000_5010;
    localparam addr_t ADDR_E   = 32'h0000_3014;
    localparam addr_t TARGET_C = 32'h0000_8000;
    localparam addr_t TARGET_D = 32'h0000_9000;
    localparam addr_t TARGET_E = 32'h0000_a000;

    logic              clock;
    logic              reset;
    addr_t             pc_start;
    resolve_bundle_t   resolve;
    prediction_group_t predictions;

    // reference tables
    history_t   model_history    [BHT_ENTRIES];
    dir_state_t model_pattern    [PHT_ENTRIES];
    logic       model_btb_valid  [BTB_ENTRIES];
    btb_tag_t   model_btb_tag    [BTB_ENTRIES];
    addr_t      model_btb_target [BTB_ENTRIES];

    // bundle that the DUT takes at the next rising edge
    resolve_bundle_t pending_bundle;

    integer seed;
    int     cycle_count;
    int     check_count;
    int     error_count;

    branch_predictor u_branch_predictor (
        .clock       (clock),
        .reset       (reset),
        .pc_start    (pc_start),
        .resolve     (resolve),
        .predictions (predictions)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic resolve_t make_slot(input logic taken, input addr_t pc,
                                           input addr_t target);
        resolve_t slot;
        slot.valid  = 1'b1;
        slot.taken  = taken;
        slot.pc     = pc;
        slot.target = target;
        return slot;
    endfunction

    function automatic prediction_t make_prediction(input logic valid, input logic taken,
                                                    input addr_t target);
        prediction_t p;
        p.valid  = valid;
        p.taken  = taken;
        p.target = target;
        return p;
    endfunction

    task automatic reset_model();
        for (int e = 0; e < BHT_ENTRIES; e++) begin
            model_history[e] = '0;
        end
        for (int e = 0; e < PHT_ENTRIES; e++) begin
            model_pattern[e] = NOT_TAKEN;
        end
        for (int e = 0; e < BTB_ENTRIES; e++) begin
            model_btb_valid[e]  = 1'b0;
            model_btb_tag[e]    = '0;
            model_btb_target[e] = '0;
        end
    endtask

    // slot order, later slots win
    task automatic update_model(input resolve_bundle_t bundle);
        history_t   old_history [BHT_ENTRIES];
        bht_index_t idx;
        old_history = model_history;
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            if (bundle[s].valid) begin
                idx = bundle[s].pc[5:2];
                // pattern entry picked by the history from before this edge
                model_pattern[old_history[idx]] = bundle[s].taken ? TAKEN : NOT_TAKEN;
                model_history[idx] = {model_history[idx][HISTORY_BITS-2:0], bundle[s].taken};
                if (bundle[s].taken) begin
                    model_btb_valid[idx]  = 1'b1;
                    model_btb_tag[idx]    = bundle[s].pc[31:6];
                    model_btb_target[idx] = bundle[s].target;
                end
            end
        end
    endtask

    function automatic prediction_group_t predict_group(input addr_t pc);
        prediction_group_t group;
        addr_t             lane_pc;
        bht_index_t        idx;
        logic              redirect;
        logic              seen;
        seen = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_pc  = pc + addr_t'(4 * i);
            idx      = lane_pc[5:2];
            redirect = (model_pattern[model_history[idx]] == TAKEN) &&
                       model_btb_valid[idx] && (model_btb_tag[idx] == lane_pc[31:6]);
            group[i].valid  = !seen;
            group[i].taken  = !seen && redirect;
            group[i].target = group[i].taken ? model_btb_target[idx] : lane_pc + addr_t'(4);
            if (redirect) begin
                seen = 1'b1;
            end
        end
        return group;
    endfunction

    task automatic compare_prediction(input prediction_t expected, input int lane);
        prediction_t actual;
        actual = predictions[lane];
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error predictions[%0d]: got valid=%h taken=%h target=%h",
                     lane, actual.valid, actual.taken, actual.target);
            $display("      expected valid=%h taken=%h target=%h",
                     expected.valid, expected.taken, expected.target);
        end
    endtask

    task automatic check_group(input addr_t pc);
        prediction_group_t group;
        group = predict_group(pc);
        for (int lane = 0; lane < FETCH_WIDTH; lane++) begin
            compare_prediction(group[lane], lane);
        end
    endtask

    // one cycle, outputs are looked at on the falling edge
    task automatic step_cycle(input resolve_bundle_t bundle, input addr_t pc);
        @(posedge clock);
        update_model(pending_bundle);
        pending_bundle = bundle;
        resolve  <= bundle;
        pc_start <= pc;
        @(negedge clock);
    endtask

    task automatic test_reset_lookup();
        addr_t pcs [4];
        pcs[0] = 32'h0000_0000;
        pcs[1] = 32'h0000_1000;
        pcs[2] = 32'h0000_1ffc;
        pcs[3] = 32'hffff_fff8;
        for (int n = 0; n < 4; n++) begin
            step_cycle('0, pcs[n]);
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                compare_prediction(make_prediction(1'b1, 1'b0, pcs[n] + addr_t'(4 * i + 4)), i);
            end
        end
    endtask

    task automatic test_single_install();
        resolve_bundle_t bundle;
        bundle    = '0;
        bundle[0] = make_slot(1'b1, ADDR_A, TARGET_A);
        step_cycle(bundle, ADDR_A);
        check_group(ADDR_A);
        // hit without a taken pattern entry
        step_cycle('0, ADDR_A);
        check_group(ADDR_A);
        compare_prediction(make_prediction(1'b1, 1'b0, ADDR_A + addr_t'(4)), 0);
    endtask

    task automatic test_history_saturation();
        resolve_bundle_t bundle;
        addr_t           pc;
        bundle    = '0;
        bundle[0] = make_slot(1'b1, ADDR_A, TARGET_A);
        pc        = ADDR_A - addr_t'(4);
        repeat (4) begin
            step_cycle(bundle, pc);
            check_group(pc);
        end
        step_cycle('0, pc);
        check_group(pc);
        compare_prediction(make_prediction(1'b1, 1'b0, ADDR_A), 0);
        compare_prediction(make_prediction(1'b1, 1'b1, TARGET_A), 1);
        compare_prediction(make_prediction(1'b0, 1'b0, ADDR_A + addr_t'(8)), 2);
        compare_prediction(make_prediction(1'b0, 1'b0, ADDR_A + addr_t'(12)), 3);
    endtask

    task automatic test_alias_miss();
        step_cycle('0, ADDR_B);
        check_group(ADDR_B);
        compare_prediction(make_prediction(1'b1, 1'b0, ADDR_B + addr_t'(4)), 0);
    endtask

    task automatic test_same_index_bundle();
        resolve_bundle_t bundle;
        bundle[0] = make_slot(1'b1, ADDR_E, TARGET_E);
        bundle[1] = make_slot(1'b0, ADDR_E, TARGET_E);
        // the last write to pattern entry 0000 is taken
        bundle[2] = make_slot(1'b1, ADDR_C, TARGET_C);
        bundle[3] = make_slot(1'b1, ADDR_D, TARGET_D);
        step_cycle(bundle, ADDR_D);
        step_cycle('0, ADDR_D);
        check_group(ADDR_D);
        compare_prediction(make_prediction(1'b1, 1'b1, TARGET_D), 0);
        compare_prediction(make_prediction(1'b0, 1'b0, ADDR_D + addr_t'(8)), 1);
        step_cycle('0, ADDR_C);
        check_group(ADDR_C);
        compare_prediction(make_prediction(1'b1, 1'b0, ADDR_C + addr_t'(4)), 0);
        // taken then not taken leaves history 0010
        step_cycle('0, ADDR_E);
        check_group(ADDR_E);
        compare_prediction(make_prediction(1'b1, 1'b0, ADDR_E + addr_t'(4)), 0);
    endtask

    task automatic test_random_bundles();
        resolve_bundle_t bundle;
        logic [31:0]     r;
        logic [31:0]     t;
        addr_t           pc;
        for (int n = 0; n < RANDOM_BUNDLES; n++) begin
            for (int s = 0; s < FETCH_WIDTH; s++) begin
                r = $random(seed);
                t = $random(seed);
                bundle[s].valid  = r[0];
                bundle[s].taken  = r[1];
                // small window so that tags alias within an index
                bundle[s].pc     = 32'h0000_1000 + {24'h0, r[13:8], 2'b00};
                bundle[s].target = {t[31:2], 2'b00};
            end
            r  = $random(seed);
            pc = 32'h0000_1000 + {24'h0, r[5:0], 2'b00};
            step_cycle(bundle, pc);
            check_group(pc);
        end
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        pc_start       = '0;
        resolve        = '0;
        pending_bundle = '0;
        seed           = 32'hc628;
        cycle_count    = 0;
        check_count    = 0;
        error_count    = 0;
        reset_model();
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        test_reset_lookup();
        test_single_install();
        test_history_saturation();
        test_alias_miss();
        test_same_index_bundle();
        test_random_bundles();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: branch_predictor.f
hdl/bp_pkg.sv
hdl/branch_target_buffer.sv
hdl/local_history_predictor.sv
hdl/fetch_target_select.sv
hdl/branch_predictor.sv
sim/branch_predictor_checker.sv
sim/branch_predictor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module branch_predictor_tb \
    -f branch_predictor.f \
    -o branch_predictor_sim \
    && ./obj_dir/branch_predictor_sim | tee /dev/stderr | grep -F 'All tests passed!' > /dev/null \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
